//--- cdp_pkg.sv
/*
  shared constants and types for the cdp front datapath
  lane layout fixed at 4 x 16 bit, fp16 fields follow ieee half precision
  fifo depth must stay a power of two (full flag is the count msb)
*/
package cdp_pkg;

  //////////////////////////////////////////////////////////////////////
  // lane and buffer constants
  //////////////////////////////////////////////////////////////////////
  localparam int cdp_lanes      = 4;
  localparam int cdp_lane_w     = 16;
  localparam int cdp_fifo_depth = 4;
  localparam int cdp_sq_w       = 34;

  // fp16 field widths, sign bit sits above the exponent
  localparam int cdp_man_w = 10;
  localparam int cdp_exp_w = 5;

  // per-beat lane count, 0..cdp_lanes
  localparam int cdp_cnt_w = $clog2(cdp_lanes + 1);

  // fifo pointer width
  localparam int cdp_ptr_w = $clog2(cdp_fifo_depth);

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////
  typedef enum logic {
    cdp_int16 = 1'b0,
    cdp_fp16  = 1'b1
  } cdp_dtype_e;

  // position flags, all three set marks layer end
  typedef struct packed {
    logic last_w;
    logic last_h;
    logic last_c;
  } cdp_info_t;

  // input beat, lane 0 in the low bits of the lane array
  typedef struct packed {
    logic [cdp_lanes-1:0][cdp_lane_w-1:0] lane;
    cdp_info_t                            info;
  } cdp_pd_t;

  // result beat
  typedef struct packed {
    logic [cdp_sq_w-1:0] sqsum;
    cdp_info_t           info;
  } cdp_out_t;

endpackage

//--- cdp_nan_filter.sv
/*
  input gate and fp16 nan/inf preprocessing
  input stays closed after reset and after every layer-end beat until op_en rises
  data_type and nan_to_zero are sampled live, keep them stable while a layer runs
  at most two finished layers may wait for layer_done at any time
*/
`timescale 1ns/1ps

module cdp_nan_filter (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  cdp_pkg::cdp_pd_t    in_pd,
  input  logic                in_valid,
  output logic                in_ready,
  input  logic                op_en,
  input  logic                nan_to_zero,
  input  cdp_pkg::cdp_dtype_e data_type,
  input  logic                layer_done,
  output cdp_pkg::cdp_pd_t    flt_pd,
  output logic                flt_valid,
  input  logic                flt_ready,
  output logic [31:0]         nan_num,
  output logic [31:0]         inf_num
);
  import cdp_pkg::*;

  typedef enum logic {
    gate_wait,
    gate_run
  } gate_e;

  gate_e                gate_st;
  logic                 op_en_d1;
  logic                 op_en_load;
  logic                 load_din;
  logic                 layer_end;
  logic                 fp16_en;
  logic [cdp_lanes-1:0] dat_is_nan;
  logic [cdp_lanes-1:0] dat_is_inf;
  logic [cdp_cnt_w-1:0] nan_beat;
  logic [cdp_cnt_w-1:0] inf_beat;
  cdp_pd_t              pd_proc;
  logic [31:0]          nan_cnt;
  logic [31:0]          inf_cnt;
  logic [31:0]          nan_total;
  logic [31:0]          inf_total;
  logic [1:0][31:0]     nan_slot;
  logic [1:0][31:0]     inf_slot;
  logic                 layer_flag;
  logic                 done_flag;

  //////////////////////////////////////////////////////////////////////
  // handshake and op_en gating
  //////////////////////////////////////////////////////////////////////
  assign in_ready  = (~flt_valid | flt_ready) & (gate_st == gate_run);
  assign load_din  = in_valid & in_ready;
  assign layer_end = load_din & (&in_pd.info);

  // rising edge of op_en
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_d1 <= 1'b0;
    end else begin
      op_en_d1 <= op_en;
    end
  end
  assign op_en_load = op_en & ~op_en_d1;

  // layer end wins over a coincident op_en edge
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      gate_st <= gate_wait;
    end else if (layer_end) begin
      gate_st <= gate_wait;
    end else if (op_en_load) begin
      gate_st <= gate_run;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // nan / inf detect and nan-to-zero
  //////////////////////////////////////////////////////////////////////
  assign fp16_en = (data_type == cdp_fp16);

  always_comb begin
    pd_proc = in_pd;
    nan_beat = '0;
    inf_beat = '0;
    for (int i = 0; i < cdp_lanes; i++) begin
      // exponent all ones, mantissa picks nan vs inf
      dat_is_nan[i] = fp16_en & (&in_pd.lane[i][cdp_man_w+cdp_exp_w-1:cdp_man_w])
                      & (|in_pd.lane[i][cdp_man_w-1:0]);
      dat_is_inf[i] = fp16_en & (&in_pd.lane[i][cdp_man_w+cdp_exp_w-1:cdp_man_w])
                      & ~(|in_pd.lane[i][cdp_man_w-1:0]);
      if (dat_is_nan[i] && nan_to_zero) begin
        pd_proc.lane[i] = '0;
      end
      nan_beat = nan_beat + cdp_cnt_w'(dat_is_nan[i]);
      inf_beat = inf_beat + cdp_cnt_w'(dat_is_inf[i]);
    end
  end

  // output stage, reloads in the cycle the old beat leaves
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      flt_valid <= 1'b0;
    end else if (load_din) begin
      flt_valid <= 1'b1;
    end else if (flt_ready) begin
      flt_valid <= 1'b0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (load_din) begin
      flt_pd <= pd_proc;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // per-layer counting
  //////////////////////////////////////////////////////////////////////
  // totals include the current beat
  assign nan_total = nan_cnt + 32'(nan_beat);
  assign inf_total = inf_cnt + 32'(inf_beat);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      nan_cnt    <= '0;
      inf_cnt    <= '0;
      layer_flag <= 1'b0;
    end else if (load_din) begin
      nan_cnt <= layer_end ? '0 : nan_total;
      inf_cnt <= layer_end ? '0 : inf_total;
      if (layer_end) begin
        layer_flag <= ~layer_flag;
      end
    end
  end

  // ping-pong park of finished layers
  always_ff @(posedge nvdla_core_clk) begin
    if (layer_end) begin
      nan_slot[layer_flag] <= nan_total;
      inf_slot[layer_flag] <= inf_total;
    end
  end

  // done pops the oldest parked slot
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      done_flag <= 1'b0;
      nan_num   <= '0;
      inf_num   <= '0;
    end else if (layer_done) begin
      done_flag <= ~done_flag;
      nan_num   <= nan_slot[done_flag];
      inf_num   <= inf_slot[done_flag];
    end
  end

endmodule

//--- cdp_dp_fifo.sv
/*
  small valid/ready buffer between the gate stage and the square-sum stage
  depth from the package, must be a power of two
  flt_ready depends combinationally on buf_ready when full
*/
`timescale 1ns/1ps

module cdp_dp_fifo (
  input  logic             nvdla_core_clk,
  input  logic             nvdla_core_rstn,
  input  cdp_pkg::cdp_pd_t flt_pd,
  input  logic             flt_valid,
  output logic             flt_ready,
  output cdp_pkg::cdp_pd_t buf_pd,
  output logic             buf_valid,
  input  logic             buf_ready
);
  import cdp_pkg::*;

  cdp_pd_t              mem [cdp_fifo_depth];
  logic [cdp_ptr_w-1:0] wr_ptr;
  logic [cdp_ptr_w-1:0] rd_ptr;
  logic [cdp_ptr_w:0]   count;
  logic                 full;
  logic                 wr_en;
  logic                 rd_en;

  // count msb set means depth entries held
  assign full      = count[cdp_ptr_w];
  assign buf_valid = (count != '0);
  // a full fifo still takes a write when the head leaves
  assign flt_ready = ~full | buf_ready;

  assign wr_en = flt_valid & flt_ready;
  assign rd_en = buf_valid & buf_ready;

  //////////////////////////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap naturally
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge nvdla_core_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= flt_pd;
    end
  end

  // head entry
  assign buf_pd = mem[rd_ptr];

endmodule

//--- cdp_sqsum.sv
/*
  per-beat sum of squares over the four lanes, lanes read as signed int16
  fp16 beats are squared as raw bit patterns, no float arithmetic here
  layer_done is combinational from the output handshake
*/
`timescale 1ns/1ps

module cdp_sqsum (
  input  logic              nvdla_core_clk,
  input  logic              nvdla_core_rstn,
  input  cdp_pkg::cdp_pd_t  buf_pd,
  input  logic              buf_valid,
  output logic              buf_ready,
  output cdp_pkg::cdp_out_t out_pd,
  output logic              out_valid,
  input  logic              out_ready,
  output logic              layer_done
);
  import cdp_pkg::*;

  logic                load_buf;
  logic [cdp_sq_w-1:0] sum_next;
  cdp_out_t            out_next;

  // single output register, take a beat when empty or draining
  assign buf_ready = ~out_valid | out_ready;
  assign load_buf  = buf_valid & buf_ready;

  //////////////////////////////////////////////////////////////////////
  // square sum
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    logic signed [cdp_lane_w-1:0]   lane_s;
    logic signed [2*cdp_lane_w-1:0] sq;
    sum_next = '0;
    for (int i = 0; i < cdp_lanes; i++) begin
      lane_s = signed'(buf_pd.lane[i]);
      // square never negative, msb of sq stays clear
      sq = lane_s * lane_s;
      sum_next = sum_next + cdp_sq_w'(sq);
    end
  end

  assign out_next.sqsum = sum_next;
  assign out_next.info  = buf_pd.info;

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_valid <= 1'b0;
    end else if (load_buf) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (load_buf) begin
      out_pd <= out_next;
    end
  end

  // layer end leaving on the out side
  assign layer_done = out_valid & out_ready & (&out_pd.info);

endmodule

//--- cdp_dp_top.sv
/*
  cdp front datapath: gate/nan filter, 4-entry buffer, square-sum stage
  three cycles from in transfer to out_valid with no stall
  counts reach nan_num/inf_num one cycle after layer_done
*/
`timescale 1ns/1ps

module cdp_dp_top (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  cdp_pkg::cdp_pd_t    in_pd,
  input  logic                in_valid,
  output logic                in_ready,
  input  logic                op_en,
  input  logic                nan_to_zero,
  input  cdp_pkg::cdp_dtype_e data_type,
  output cdp_pkg::cdp_out_t   out_pd,
  output logic                out_valid,
  input  logic                out_ready,
  output logic                layer_done,
  output logic [31:0]         nan_num,
  output logic [31:0]         inf_num
);
  import cdp_pkg::*;

  // filter to fifo
  cdp_pd_t flt_pd;
  logic    flt_valid;
  logic    flt_ready;
  // fifo to square sum
  cdp_pd_t buf_pd;
  logic    buf_valid;
  logic    buf_ready;

  cdp_nan_filter u_nan_filter (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_pd           (in_pd),
    .in_valid        (in_valid),
    .in_ready        (in_ready),
    .op_en           (op_en),
    .nan_to_zero     (nan_to_zero),
    .data_type       (data_type),
    .layer_done      (layer_done),
    .flt_pd          (flt_pd),
    .flt_valid       (flt_valid),
    .flt_ready       (flt_ready),
    .nan_num         (nan_num),
    .inf_num         (inf_num)
  );

  cdp_dp_fifo u_dp_fifo (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .flt_pd          (flt_pd),
    .flt_valid       (flt_valid),
    .flt_ready       (flt_ready),
    .buf_pd          (buf_pd),
    .buf_valid       (buf_valid),
    .buf_ready       (buf_ready)
  );

  // done pulse also feeds back into the filter counters
  cdp_sqsum u_sqsum (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .buf_pd          (buf_pd),
    .buf_valid       (buf_valid),
    .buf_ready       (buf_ready),
    .out_pd          (out_pd),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .layer_done      (layer_done)
  );

endmodule

//--- tb_clk_gen.sv
/*
  free running testbench clock, 8 ns period
  starts low at time zero
*/
`timescale 1ns/1ps

module tb_clk_gen (
  output logic nvdla_core_clk
);

  // half period 4 ns
  initial begin
    nvdla_core_clk = 1'b0;
    forever #4 nvdla_core_clk = ~nvdla_core_clk;
  end

endmodule

//--- cdp_dp_assert.sv
/*
  concurrent checks on the cdp datapath handshakes and the op_en gate
  bound into cdp_dp_top, needs assertion support enabled in the simulator
*/
`timescale 1ns/1ps

module cdp_dp_assert (
  input logic               nvdla_core_clk,
  input logic               nvdla_core_rstn,
  input cdp_pkg::cdp_pd_t   in_pd,
  input logic               in_valid,
  input logic               in_ready,
  input logic               op_en,
  input cdp_pkg::cdp_out_t  out_pd,
  input logic               out_valid,
  input logic               out_ready,
  input logic               layer_done
);
  import cdp_pkg::*;

  logic op_en_q;
  logic gate_closed;

  // gate closed from reset or layer end until an op_en rising edge
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_q     <= 1'b0;
      gate_closed <= 1'b1;
    end else begin
      op_en_q <= op_en;
      if (in_valid && in_ready && (&in_pd.info)) begin
        gate_closed <= 1'b1;
      end else if (op_en && !op_en_q) begin
        gate_closed <= 1'b0;
      end
    end
  end

  // stalled output holds still
  a_out_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    out_valid && !out_ready |=> out_valid && $stable(out_pd))
    else $error("out_pd changed while stalled");

  a_gate: assert property (@(posedge nvdla_core_clk)
    (!nvdla_core_rstn || gate_closed) |-> !in_ready)
    else $error("in_ready high while the gate is closed");

  // done is a single-cycle pulse
  a_done_pulse: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    layer_done |=> !layer_done)
    else $error("layer_done high two cycles in a row");

endmodule

bind cdp_dp_top cdp_dp_assert u_dp_assert (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .in_pd           (in_pd),
  .in_valid        (in_valid),
  .in_ready        (in_ready),
  .op_en           (op_en),
  .out_pd          (out_pd),
  .out_valid       (out_valid),
  .out_ready       (out_ready),
  .layer_done      (layer_done)
);

//--- tb_cdp_dp_top.sv
/*
  table driven testbench for cdp_dp_top
  one table row per layer
  beats are driven on falling edges
  expected sums and counts come from a reference model of the lane rules
  filler lanes and out_ready stalls come from an lcg with a fixed seed
*/
`timescale 1ns/1ps

module tb_cdp_dp_top;
  import cdp_pkg::*;

  localparam int          n_rows   = 6;
  localparam logic [31:0] lcg_seed = 32'hb465_44d2;

  // one layer of stimulus
  typedef struct packed {
    cdp_dtype_e       dtype;
    logic             n2z;
    logic [31:0]      beats;
    logic [3:0]       fix;
    logic [3:0][15:0] pat;
    logic [1:0]       stall;
  } row_t;

  logic                nvdla_core_clk;
  logic                nvdla_core_rstn;
  cdp_pd_t             in_pd;
  logic                in_valid;
  logic                in_ready;
  logic                op_en;
  logic                nan_to_zero;
  cdp_dtype_e          data_type;
  cdp_out_t            out_pd;
  logic                out_valid;
  logic                out_ready;
  logic                layer_done;
  logic [31:0]         nan_num;
  logic [31:0]         inf_num;

  row_t                rows [n_rows];
  logic [31:0]         data_st;
  logic [1:0]          cur_stall;
  cdp_out_t            exp_q [$];
  logic [31:0]         nan_q [$];
  logic [31:0]         inf_q [$];
  int                  done_cnt;

  tb_clk_gen u_clk (.nvdla_core_clk(nvdla_core_clk));

  cdp_dp_top uut (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_pd           (in_pd),
    .in_valid        (in_valid),
    .in_ready        (in_ready),
    .op_en           (op_en),
    .nan_to_zero     (nan_to_zero),
    .data_type       (data_type),
    .out_pd          (out_pd),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .layer_done      (layer_done),
    .nan_num         (nan_num),
    .inf_num         (inf_num)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model and helpers
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // lane class 0 plain 1 nan 2 inf
  // only fp16 lanes are classified
  function automatic logic [1:0] lane_kind(input cdp_dtype_e dt, input logic [15:0] v);
    if (dt != cdp_fp16 || v[14:10] != 5'h1f) begin
      return 2'd0;
    end
    return (v[9:0] != 10'h0) ? 2'd1 : 2'd2;
  endfunction

  // square sum of the signed lanes after nan-to-zero
  function automatic cdp_out_t model_beat(input cdp_dtype_e dt, input logic n2z,
                                          input cdp_pd_t pd);
    cdp_out_t    o;
    longint      acc;
    longint      s;
    logic [15:0] v;
    acc = 0;
    for (int i = 0; i < cdp_lanes; i++) begin
      v = pd.lane[i];
      if (n2z && lane_kind(dt, v) == 2'd1) begin
        v = '0;
      end
      s = longint'($signed(v));
      acc += s * s;
    end
    o.sqsum = acc[cdp_sq_w-1:0];
    o.info  = pd.info;
    return o;
  endfunction

  // fixed lanes from the row and random filler elsewhere
  function automatic cdp_pd_t build_beat(input row_t row, input int k);
    cdp_pd_t pd;
    logic    last;
    last = (k == row.beats - 1);
    for (int i = 0; i < cdp_lanes; i++) begin
      data_st = lcg_step(data_st);
      pd.lane[i] = row.fix[i] ? row.pat[i] : data_st[31:16];
    end
    pd.info.last_w = (k % 2 == 1) || last;
    pd.info.last_h = (k % 3 == 2) || last;
    pd.info.last_c = last;
    return pd;
  endfunction

  task automatic check_out(input string name, input cdp_out_t got, input cdp_out_t exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      $display("Some tests failed");
      $fatal(1, "output beat mismatch");
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
      $display("Some tests failed");
      $fatal(1, "count mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got=%b exp=%b", $time, name, got, exp);
      $display("Some tests failed");
      $fatal(1, "control bit mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin : stimulus
    cdp_pd_t    pd;
    logic [1:0] kind;
    int         nan_l;
    int         inf_l;
    nvdla_core_rstn = 1'b0;
    in_pd           = '0;
    in_valid        = 1'b0;
    op_en           = 1'b0;
    nan_to_zero     = 1'b0;
    data_type       = cdp_int16;
    cur_stall       = 2'd0;
    data_st         = lcg_seed;
    done_cnt        = 0;
    // negative int16 lanes and fp16 nan/inf with and without zeroing under stalls
    rows[0] = '{cdp_int16, 1'b0, 32'd6, 4'b0101,
                {16'h0000, 16'h8000, 16'h0000, 16'hfff3}, 2'd0};
    rows[1] = '{cdp_fp16,  1'b1, 32'd5, 4'b1011,
                {16'hfe00, 16'h0000, 16'hfc00, 16'h7c01}, 2'd2};
    rows[2] = '{cdp_fp16,  1'b0, 32'd1, 4'b1111,
                {16'h7c00, 16'hffff, 16'h7e00, 16'h3c00}, 2'd1};
    rows[3] = '{cdp_fp16,  1'b0, 32'd7, 4'b0010,
                {16'h0000, 16'h0000, 16'h7d55, 16'h0000}, 2'd1};
    rows[4] = '{cdp_int16, 1'b1, 32'd5, 4'b1111,
                {16'h7c00, 16'h7c01, 16'h8001, 16'hffff}, 2'd3};
    rows[5] = '{cdp_fp16,  1'b1, 32'd4, 4'b1100,
                {16'hfc00, 16'h7fff, 16'h0000, 16'h0000}, 2'd2};

    repeat (10) @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;

    // reset state
    @(negedge nvdla_core_clk);
    #1;
    check_bit("in_ready", in_ready, 1'b0);
    check_bit("out_valid", out_valid, 1'b0);
    check_bit("layer_done", layer_done, 1'b0);
    check_count("nan_num", nan_num, 32'd0);
    check_count("inf_num", inf_num, 32'd0);

    for (int r = 0; r < n_rows; r++) begin
      @(negedge nvdla_core_clk);
      data_type   = rows[r].dtype;
      nan_to_zero = rows[r].n2z;
      cur_stall   = rows[r].stall;
      nan_l       = 0;
      inf_l       = 0;
      pd          = build_beat(rows[r], 0);
      in_pd       = pd;
      in_valid    = 1'b1;
      // gate stays shut without an op_en edge, even with op_en still high
      repeat (4) begin
        #1;
        check_bit("in_ready", in_ready, 1'b0);
        @(negedge nvdla_core_clk);
      end
      // one low cycle so the next rise is an edge
      op_en = 1'b0;
      @(negedge nvdla_core_clk);
      op_en = 1'b1;
      for (int k = 0; k < rows[r].beats; k++) begin
        if (k > 0) begin
          pd    = build_beat(rows[r], k);
          in_pd = pd;
        end
        #1;
        while (!in_ready) begin
          @(negedge nvdla_core_clk);
          #1;
        end
        // transfer lands on the coming rising edge
        exp_q.push_back(model_beat(rows[r].dtype, rows[r].n2z, pd));
        for (int i = 0; i < cdp_lanes; i++) begin
          kind = lane_kind(rows[r].dtype, pd.lane[i]);
          if (kind == 2'd1) begin
            nan_l++;
          end else if (kind == 2'd2) begin
            inf_l++;
          end
        end
        @(negedge nvdla_core_clk);
      end
      in_valid = 1'b0;
      nan_q.push_back(nan_l);
      inf_q.push_back(inf_l);
    end

    // drain and idle a few cycles to catch extra beats
    while (exp_q.size() != 0 || nan_q.size() != 0) begin
      @(negedge nvdla_core_clk);
    end
    repeat (6) @(negedge nvdla_core_clk);
    if (done_cnt == n_rows) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("layer_done pulsed %0d times for %0d layers", done_cnt, n_rows);
      $display("Some tests failed");
      $fatal(1, "wrong number of layer_done pulses");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // out side stalls and checks
  //////////////////////////////////////////////////////////////////////
  initial begin : out_side
    logic [31:0] st;
    cdp_out_t    e;
    logic        done_exp;
    logic        cnt_pending;
    logic [31:0] pend_nan;
    logic [31:0] pend_inf;
    st          = lcg_seed;
    out_ready   = 1'b0;
    cnt_pending = 1'b0;
    pend_nan    = '0;
    pend_inf    = '0;
    @(posedge nvdla_core_rstn);
    forever begin
      @(negedge nvdla_core_clk);
      st = lcg_step(st);
      out_ready = (st[17:16] >= cur_stall);
      #1;
      // counts land one cycle after the done pulse
      if (cnt_pending) begin
        check_count("nan_num", nan_num, pend_nan);
        check_count("inf_num", inf_num, pend_inf);
        cnt_pending = 1'b0;
      end
      done_exp = 1'b0;
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("output beat at t=%0t with no input beat left to match it", $time);
          $display("Some tests failed");
          $fatal(1, "extra output beat");
        end
        e = exp_q.pop_front();
        check_out("out_pd", out_pd, e);
        done_exp = &e.info;
      end
      check_bit("layer_done", layer_done, done_exp);
      if (done_exp) begin
        pend_nan    = nan_q.pop_front();
        pend_inf    = inf_q.pop_front();
        cnt_pending = 1'b1;
        done_cnt++;
      end
    end
  end

  // run limit from the table length
  initial begin : watchdog
    int limit;
    @(posedge nvdla_core_rstn);
    limit = 200;
    for (int r = 0; r < n_rows; r++) begin
      limit += rows[r].beats * 20;
    end
    repeat (limit) @(posedge nvdla_core_clk);
    $display("timeout after %0d cycles, the datapath stopped making progress", limit);
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- cdp_dp_top.f
cdp_pkg.sv
cdp_nan_filter.sv
cdp_dp_fifo.sv
cdp_sqsum.sv
cdp_dp_top.sv
tb_clk_gen.sv
cdp_dp_assert.sv
tb_cdp_dp_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cdp datapath testbench with verilator
# the result is taken from sim.log

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f cdp_dp_top.f --top-module tb_cdp_dp_top \
  -o sim_cdp_dp > build.log 2>&1 && ./obj_dir/sim_cdp_dp > sim.log 2>&1 \
  || echo "Some tests failed" >> sim.log

grep -q "Some tests failed" sim.log && { echo "FAIL, see build.log and sim.log"; exit 1; }
grep -q "All tests passed" sim.log || { echo "FAIL, no verdict in sim.log"; exit 1; }
echo "PASS"
